// ==== Makefile ====
# Verilator build and run of the VTP testbench

TOP := tb_vtp_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -Wno-fatal -f vlog.f --top-module $(TOP) --Mdir obj_dir -o $(TOP)

# The run passes only if the log holds the pass line
run: build
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module vtp_top

clean:
	rm -rf obj_dir $(LOG)

// ==== rtl/vtp_fill_if.sv ====
/*
 * VTP fill interface
 * Carries one finished page walk, hit or fault, from the walker to the TLB
 */

`timescale 1ns/1ns
`default_nettype none

interface vtp_fill_if;

    // A fill transfers when fill_en and fill_rdy are both high
    logic               fill_en;
    vtp_pkg::t_va_page  fill_va;
    vtp_pkg::t_pa_idx   fill_pa;
    // Page not present in the table, fill_pa is then zero
    logic               fill_fault;
    logic               fill_rdy;

    modport walker
    (
        output fill_en, fill_va, fill_pa, fill_fault,
        input  fill_rdy
    );

    modport tlb
    (
        input  fill_en, fill_va, fill_pa, fill_fault,
        output fill_rdy
    );

endinterface

`default_nettype wire

// ==== rtl/vtp_pkg.sv ====
/*
 * VTP shared definitions
 * Page table geometry, PTE and line types, and the FSM state encodings
 * used by the TLB and the page table walker
 */

`default_nettype none

package vtp_pkg;

    // ==================================================================
    // Page table geometry
    // ==================================================================

    // Virtual page number and the split into hash index and stored tag
    localparam int va_page_bits  = 16;
    localparam int hash_idx_bits = 4;
    localparam int va_tag_bits   = va_page_bits - hash_idx_bits;
    localparam int pa_idx_bits   = 12;

    // Lines 0 to 15 are hash heads, the rest is overflow space
    localparam int pt_lines      = 64;
    localparam int pte_idx_bits  = 6;
    localparam int line_bits     = 128;

    // A PTE takes 3 bytes and the last byte of a line is the next pointer
    localparam int pte_bytes     = (va_tag_bits + pa_idx_bits + 7) / 8;
    localparam int line_bytes    = line_bits / 8;
    localparam int ptes_per_line = (line_bytes - 1) / pte_bytes;

    typedef logic [va_page_bits-1:0]  t_va_page;
    typedef logic [va_tag_bits-1:0]   t_va_tag;
    typedef logic [hash_idx_bits-1:0] t_hash_idx;
    typedef logic [pa_idx_bits-1:0]   t_pa_idx;
    typedef logic [pte_idx_bits-1:0]  t_pte_idx;
    typedef logic [line_bits-1:0]     t_pt_line;

    // Tag sits in the upper bits, the physical page in the lower bits
    typedef struct packed
    {
        t_va_tag tag;
        t_pa_idx pa;
    } t_pte;

    typedef enum logic [2:0]
    {
        walk_idle,
        walk_read_req,
        walk_read_rsp,
        walk_search,
        walk_fill
    } t_walk_state;

    typedef enum logic [1:0]
    {
        tlb_idle,
        tlb_check,
        tlb_walk,
        tlb_respond
    } t_tlb_state;

endpackage

`default_nettype wire

// ==== rtl/vtp_pt_mem.sv ====
/*
 * VTP page table memory
 * Line array filled and read back 32 bits at a time by the host over APB,
 * and read a whole line at a time by the page table walker
 */

`timescale 1ns/1ns
`default_nettype none

module vtp_pt_mem
(
    input  wire logic          clk,
    input  wire logic          reset,

    // APB slave, bits 9 to 4 pick the line and bits 3 to 2 the word
    input  wire logic [vtp_pkg::pte_idx_bits+3:0] paddr,
    input  wire logic          psel,
    input  wire logic          penable,
    input  wire logic          pwrite,
    input  wire logic [31:0]   pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,

    // Walker read port with one cycle of latency
    input  wire logic          pt_read_en,
    input  vtp_pkg::t_pte_idx  pt_read_idx,
    output logic               pt_read_rdy,
    output logic               pt_read_data_en,
    output vtp_pkg::t_pt_line  pt_read_data
);

    vtp_pkg::t_pt_line mem [vtp_pkg::pt_lines];

    vtp_pkg::t_pte_idx apb_line;
    logic [1:0]        apb_word;
    logic              apb_access;

    assign apb_line   = paddr[vtp_pkg::pte_idx_bits+3:4];
    assign apb_word   = paddr[3:2];
    assign apb_access = psel && penable;

    // APB writes land at the end of the access phase
    always_ff @(posedge clk)
    begin
        if (apb_access && pwrite)
        begin
            mem[apb_line][apb_word*32 +: 32] <= pwdata;
        end
        if (pt_read_en)
        begin
            pt_read_data <= mem[pt_read_idx];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pt_read_data_en <= 1'b0;
        end
        else
        begin
            pt_read_data_en <= pt_read_en;
        end
    end

    // No wait states and no error responses
    assign prdata  = mem[apb_line][apb_word*32 +: 32];
    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    // The walker is held off while the host owns the array
    assign pt_read_rdy = !apb_access;

endmodule

`default_nettype wire

// ==== rtl/vtp_pt_walk.sv ====
/*
 * VTP page table walker
 * Searches the hashed page table for a virtual page missed by the TLB.
 * Starts at the hash head line, scans one PTE per cycle and follows the
 * next pointers through overflow lines, then reports a PA or a fault
 */

`timescale 1ns/1ns
`default_nettype none

module vtp_pt_walk
(
    input  wire logic               clk,
    input  wire logic               reset,

    // Walk request from the TLB
    input  wire logic               walk_req_en,
    input  vtp_pkg::t_va_page       walk_req_va,
    output logic                    walk_req_rdy,

    // Finished walk back to the TLB
    vtp_fill_if.walker              fill,

    // Line reads from the page table memory
    output logic                    pt_read_en,
    output vtp_pkg::t_pte_idx       pt_read_idx,
    input  wire logic               pt_read_rdy,
    input  wire logic               pt_read_data_en,
    input  vtp_pkg::t_pt_line       pt_read_data
);

    // Counts the PTEs still to be examined in the buffered line
    localparam int pte_num_bits = $clog2(vtp_pkg::ptes_per_line + 1);

    vtp_pkg::t_walk_state state;

    // Line being searched, shifted down one PTE per search cycle
    vtp_pkg::t_pt_line    pt_line;
    logic [pte_num_bits-1:0] pte_num;

    // Request being walked
    vtp_pkg::t_va_tag     va_tag;
    vtp_pkg::t_hash_idx   hash_idx;
    vtp_pkg::t_pte_idx    pte_idx;

    // Walk result, held for the fill
    vtp_pkg::t_pa_idx     found_pa;
    logic                 found_fault;

    // The PTE under test is always in the low bytes of the buffer
    vtp_pkg::t_pte        cur_pte;
    vtp_pkg::t_pte_idx    next_idx;

    assign cur_pte  = pt_line[$bits(vtp_pkg::t_pte)-1:0];
    // After all PTEs are shifted out the next pointer byte is at the bottom
    assign next_idx = pt_line[vtp_pkg::pte_idx_bits-1:0];

    // Only one walk at a time
    assign walk_req_rdy = (state == vtp_pkg::walk_idle);

    // ==================================================================
    // Walker FSM
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= vtp_pkg::walk_idle;
        end
        else
        begin
            case (state)
                vtp_pkg::walk_idle:
                begin
                    if (walk_req_en)
                    begin
                        state <= vtp_pkg::walk_read_req;
                    end
                end

                // Hold until the memory is free of APB traffic
                vtp_pkg::walk_read_req:
                begin
                    if (pt_read_rdy)
                    begin
                        state <= vtp_pkg::walk_read_rsp;
                    end
                end

                vtp_pkg::walk_read_rsp:
                begin
                    if (pt_read_data_en)
                    begin
                        state <= vtp_pkg::walk_search;
                    end
                end

                vtp_pkg::walk_search:
                begin
                    if (pte_num == '0)
                    begin
                        // Line exhausted, a null pointer ends the chain
                        if (next_idx == '0)
                        begin
                            state <= vtp_pkg::walk_fill;
                        end
                        else
                        begin
                            state <= vtp_pkg::walk_read_req;
                        end
                    end
                    else if (cur_pte.tag == va_tag || cur_pte.tag == '0)
                    begin
                        // Either a match or a null tag, both end the walk
                        state <= vtp_pkg::walk_fill;
                    end
                end

                vtp_pkg::walk_fill:
                begin
                    if (fill.fill_rdy)
                    begin
                        state <= vtp_pkg::walk_idle;
                    end
                end

                default:
                begin
                    state <= vtp_pkg::walk_idle;
                end
            endcase
        end
    end

    // ==================================================================
    // Search datapath
    // ==================================================================

    always_ff @(posedge clk)
    begin
        // Latch the request and point at its hash head line
        if (state == vtp_pkg::walk_idle && walk_req_en)
        begin
            {va_tag, hash_idx} <= walk_req_va;
            pte_idx <= vtp_pkg::t_pte_idx'(walk_req_va[vtp_pkg::hash_idx_bits-1:0]);
        end

        if (state == vtp_pkg::walk_read_rsp)
        begin
            pt_line <= pt_read_data;
            pte_num <= pte_num_bits'(vtp_pkg::ptes_per_line);
        end

        if (state == vtp_pkg::walk_search)
        begin
            // Moves the next PTE into place for the following cycle
            pt_line <= pt_line >> (8 * vtp_pkg::pte_bytes);
            pte_num <= pte_num - 1'b1;

            if (pte_num == '0)
            begin
                pte_idx     <= next_idx;
                found_pa    <= '0;
                found_fault <= 1'b1;
            end
            else if (cur_pte.tag == va_tag)
            begin
                found_pa    <= cur_pte.pa;
                found_fault <= 1'b0;
            end
            else
            begin
                // Only used if this PTE holds the null tag
                found_pa    <= '0;
                found_fault <= 1'b1;
            end
        end
    end

    // Read request is issued only while the memory can take it
    assign pt_read_en  = pt_read_rdy && (state == vtp_pkg::walk_read_req);
    assign pt_read_idx = pte_idx;

    // Result is offered for one cycle and the TLB takes it at once
    assign fill.fill_en    = (state == vtp_pkg::walk_fill);
    assign fill.fill_va    = {va_tag, hash_idx};
    assign fill.fill_pa    = found_pa;
    assign fill.fill_fault = found_fault;

endmodule

`default_nettype wire

// ==== rtl/vtp_tlb.sv ====
/*
 * VTP direct-mapped TLB
 * Answers lookups from its own entries and asks the page table walker on
 * a miss. Successful walks are installed, faults are only reported
 */

`timescale 1ns/1ns
`default_nettype none

module vtp_tlb
#(
    parameter int tlb_entries = 16
)
(
    input  wire logic          clk,
    input  wire logic          reset,

    // Lookup side
    input  wire logic          lookup_en,
    input  vtp_pkg::t_va_page  lookup_va,
    output logic               lookup_rdy,
    output logic               rsp_valid,
    output vtp_pkg::t_pa_idx   rsp_pa,
    output logic               rsp_not_present,

    // Walk request to the walker
    output logic               walk_req_en,
    output vtp_pkg::t_va_page  walk_req_va,
    input  wire logic          walk_req_rdy,

    // Finished walk from the walker
    vtp_fill_if.tlb            fill
);

    // Entry index comes from the low VA bits, the rest is the tag
    localparam int idx_bits = $clog2(tlb_entries);
    localparam int tag_bits = vtp_pkg::va_page_bits - idx_bits;

    vtp_pkg::t_tlb_state state;

    logic [tlb_entries-1:0] valid;
    logic [tag_bits-1:0]    tag_mem [tlb_entries];
    vtp_pkg::t_pa_idx       pa_mem  [tlb_entries];

    vtp_pkg::t_va_page      cur_va;
    logic [idx_bits-1:0]    cur_idx;
    logic [tag_bits-1:0]    cur_tag;
    logic [idx_bits-1:0]    fill_idx;
    logic                   hit;

    // Set once the walker has taken the request for the current miss
    logic                   req_sent;

    assign cur_idx  = cur_va[idx_bits-1:0];
    assign cur_tag  = cur_va[vtp_pkg::va_page_bits-1:idx_bits];
    assign fill_idx = fill.fill_va[idx_bits-1:0];
    assign hit      = valid[cur_idx] && (tag_mem[cur_idx] == cur_tag);

    // ==================================================================
    // Lookup FSM
    // ==================================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state    <= vtp_pkg::tlb_idle;
            valid    <= '0;
            req_sent <= 1'b0;
        end
        else
        begin
            case (state)
                vtp_pkg::tlb_idle:
                begin
                    if (lookup_en)
                    begin
                        state <= vtp_pkg::tlb_check;
                    end
                end

                vtp_pkg::tlb_check:
                begin
                    state <= hit ? vtp_pkg::tlb_respond : vtp_pkg::tlb_walk;
                end

                vtp_pkg::tlb_walk:
                begin
                    if (walk_req_en && walk_req_rdy)
                    begin
                        req_sent <= 1'b1;
                    end
                    if (fill.fill_en)
                    begin
                        // Faults are reported but never cached
                        if (!fill.fill_fault)
                        begin
                            valid[fill_idx] <= 1'b1;
                        end
                        req_sent <= 1'b0;
                        state    <= vtp_pkg::tlb_respond;
                    end
                end

                vtp_pkg::tlb_respond:
                begin
                    state <= vtp_pkg::tlb_idle;
                end

                default:
                begin
                    state <= vtp_pkg::tlb_idle;
                end
            endcase
        end
    end

    // Entry contents and response payload
    always_ff @(posedge clk)
    begin
        if (lookup_en && lookup_rdy)
        begin
            cur_va <= lookup_va;
        end

        if (state == vtp_pkg::tlb_check)
        begin
            rsp_pa          <= pa_mem[cur_idx];
            rsp_not_present <= 1'b0;
        end

        if (state == vtp_pkg::tlb_walk && fill.fill_en)
        begin
            // A fault leaves the entry as it was
            if (!fill.fill_fault)
            begin
                tag_mem[fill_idx] <= fill.fill_va[vtp_pkg::va_page_bits-1:idx_bits];
                pa_mem[fill_idx]  <= fill.fill_pa;
            end
            rsp_pa          <= fill.fill_pa;
            rsp_not_present <= fill.fill_fault;
        end
    end

    assign lookup_rdy    = (state == vtp_pkg::tlb_idle);
    assign rsp_valid     = (state == vtp_pkg::tlb_respond);
    assign walk_req_en   = (state == vtp_pkg::tlb_walk) && !req_sent;
    assign walk_req_va   = cur_va;
    assign fill.fill_rdy = (state == vtp_pkg::tlb_walk);

endmodule

`default_nettype wire

// ==== rtl/vtp_top.sv ====
/*
 * VTP translation subsystem top level
 * Connects the TLB, the page table walker and the page table memory
 */

`timescale 1ns/1ns
`default_nettype none

module vtp_top
#(
    parameter int tlb_entries = 16
)
(
    input  wire logic          clk,
    input  wire logic          reset,

    // Host access to the page table
    input  wire logic [vtp_pkg::pte_idx_bits+3:0] paddr,
    input  wire logic          psel,
    input  wire logic          penable,
    input  wire logic          pwrite,
    input  wire logic [31:0]   pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,

    // Client lookups
    input  wire logic          lookup_en,
    input  vtp_pkg::t_va_page  lookup_va,
    output logic               lookup_rdy,
    output logic               rsp_valid,
    output vtp_pkg::t_pa_idx   rsp_pa,
    output logic               rsp_not_present
);

    logic              walk_req_en;
    vtp_pkg::t_va_page walk_req_va;
    logic              walk_req_rdy;

    logic              pt_read_en;
    vtp_pkg::t_pte_idx pt_read_idx;
    logic              pt_read_rdy;
    logic              pt_read_data_en;
    vtp_pkg::t_pt_line pt_read_data;

    vtp_fill_if fill ();

    vtp_tlb #(
        .tlb_entries     (tlb_entries)
    ) i_vtp_tlb (
        .clk             (clk),
        .reset           (reset),
        .lookup_en       (lookup_en),
        .lookup_va       (lookup_va),
        .lookup_rdy      (lookup_rdy),
        .rsp_valid       (rsp_valid),
        .rsp_pa          (rsp_pa),
        .rsp_not_present (rsp_not_present),
        .walk_req_en     (walk_req_en),
        .walk_req_va     (walk_req_va),
        .walk_req_rdy    (walk_req_rdy),
        .fill            (fill.tlb)
    );

    vtp_pt_walk i_vtp_pt_walk (
        .clk             (clk),
        .reset           (reset),
        .walk_req_en     (walk_req_en),
        .walk_req_va     (walk_req_va),
        .walk_req_rdy    (walk_req_rdy),
        .fill            (fill.walker),
        .pt_read_en      (pt_read_en),
        .pt_read_idx     (pt_read_idx),
        .pt_read_rdy     (pt_read_rdy),
        .pt_read_data_en (pt_read_data_en),
        .pt_read_data    (pt_read_data)
    );

    vtp_pt_mem i_vtp_pt_mem (
        .clk             (clk),
        .reset           (reset),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .pt_read_en      (pt_read_en),
        .pt_read_idx     (pt_read_idx),
        .pt_read_rdy     (pt_read_rdy),
        .pt_read_data_en (pt_read_data_en),
        .pt_read_data    (pt_read_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_vtp_top.sv ====
/*
 * Testbench for the VTP translation subsystem
 * Replays a trace of APB accesses and lookups against the DUT and checks
 * read data, translated pages, faults and the TLB hit latency
 */

`timescale 1ns/1ns
`default_nettype none

module tb_vtp_top;

    localparam int timeout_cycles = 500;
    localparam int trace_depth    = 128;

    logic                             clk;
    logic                             reset;
    logic [vtp_pkg::pte_idx_bits+3:0] paddr;
    logic                             psel;
    logic                             penable;
    logic                             pwrite;
    logic [31:0]                      pwdata;
    logic [31:0]                      prdata;
    logic                             pready;
    logic                             pslverr;
    logic                             lookup_en;
    vtp_pkg::t_va_page                lookup_va;
    logic                             lookup_rdy;
    logic                             rsp_valid;
    vtp_pkg::t_pa_idx                 rsp_pa;
    logic                             rsp_not_present;

    // Record fields: kind, address or VA, data or PA, not-present, hit
    logic [59:0]                      trace [trace_depth];
    logic [31:0]                      lfsr;
    int                               error_count;
    int                               check_count;

    vtp_top #(
        .tlb_entries     (16)
    ) i_vtp_top (
        .clk             (clk),
        .reset           (reset),
        .paddr           (paddr),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .lookup_en       (lookup_en),
        .lookup_va       (lookup_va),
        .lookup_rdy      (lookup_rdy),
        .rsp_valid       (rsp_valid),
        .rsp_pa          (rsp_pa),
        .rsp_not_present (rsp_not_present)
    );

    // 100 ns clock period
    always #50 clk = ~clk;

    // Right-shifting Galois LFSR, one call per bit taken
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0])
        begin
            lfsr_next = (state >> 1) ^ 32'h80200003;
        end
        else
        begin
            lfsr_next = state >> 1;
        end
    endfunction

    // Waits 0 to 7 idle cycles drawn from three LFSR bits
    task automatic idle_gap();
        logic [2:0] gap;
        int         i;
        gap = '0;
        for (i = 0; i < 3; i++)
        begin
            gap  = {gap[1:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        repeat (gap) @(negedge clk);
    endtask

    // ==================================================================
    // APB master, called and returning on a falling edge
    // ==================================================================

    task automatic apb_transfer(input logic write, input logic [9:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        // Setup phase
        paddr   = addr;
        pwrite  = write;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        // Access phase ends at the first rising edge with pready high
        penable = 1'b1;
        cycles  = 0;
        while (!pready && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        rdata = prdata;
        if (!pready)
        begin
            $display("APB access to address %h got no pready within %0d cycles",
                     addr, timeout_cycles);
            error_count++;
        end
        if (pslverr)
        begin
            $display("error %0t: APB access to address %h returned pslverr", $time, addr);
            error_count++;
        end
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // ==================================================================
    // Lookup driver and response check
    // ==================================================================

    task automatic run_lookup(input vtp_pkg::t_va_page va, input vtp_pkg::t_pa_idx exp_pa,
                              input logic exp_np, input logic exp_hit);
        int cycles;
        int latency;
        idle_gap();
        cycles = 0;
        while (!lookup_rdy && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
        end
        if (!lookup_rdy)
        begin
            $display("Timed out after %0d cycles waiting for lookup_rdy before VA %h",
                     timeout_cycles, va);
            error_count++;
        end
        else
        begin
            lookup_en = 1'b1;
            lookup_va = va;
            // The next rising edge accepts the lookup
            @(negedge clk);
            lookup_en = 1'b0;
            latency   = 1;
            while (!rsp_valid && latency < timeout_cycles)
            begin
                @(negedge clk);
                latency++;
            end
            check_count++;
            if (!rsp_valid)
            begin
                $display("Timed out after %0d cycles waiting for rsp_valid for VA %h",
                         timeout_cycles, va);
                error_count++;
            end
            else
            begin
                if (rsp_pa !== exp_pa || rsp_not_present !== exp_np)
                begin
                    $display("error %0t: VA %h gave PA %h fault %b, expected PA %h fault %b",
                             $time, va, rsp_pa, rsp_not_present, exp_pa, exp_np);
                    error_count++;
                end
                // A TLB hit answers in check then respond
                if (exp_hit && latency != 2)
                begin
                    $display("error %0t: VA %h answered after %0d cycles, expected a hit in 2",
                             $time, va, latency);
                    error_count++;
                end
                if (!exp_hit && latency <= 2)
                begin
                    $display("error %0t: VA %h answered after %0d cycles, expected a walk",
                             $time, va, latency);
                    error_count++;
                end
            end
        end
    endtask

    // ==================================================================
    // Main sequence
    // ==================================================================

    initial
    begin
        logic [59:0] rec;
        logic [31:0] rdata;
        int          idx;
        logic        done;
        clk         = 1'b0;
        reset       = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        lookup_en   = 1'b0;
        lookup_va   = '0;
        lfsr        = 32'he2efe10b;
        error_count = 0;
        check_count = 0;
        $readmemh("tb/vtp_trace.txt", trace);

        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        if (!lookup_rdy || rsp_valid)
        begin
            $display("error %0t: lookup_rdy %b rsp_valid %b after reset",
                     $time, lookup_rdy, rsp_valid);
            error_count++;
        end

        // Records run until the first kind that is not 1, 2 or 3
        idx  = 0;
        done = 1'b0;
        while (!done && idx < trace_depth)
        begin
            rec = trace[idx];
            case (rec[59:56])
                4'h1:
                begin
                    apb_transfer(1'b1, rec[49:40], rec[39:8], rdata);
                end
                4'h2:
                begin
                    apb_transfer(1'b0, rec[49:40], '0, rdata);
                    check_count++;
                    if (rdata !== rec[39:8])
                    begin
                        $display("error %0t: APB read of %h returned %h, expected %h",
                                 $time, rec[49:40], rdata, rec[39:8]);
                        error_count++;
                    end
                end
                4'h3:
                begin
                    run_lookup(rec[55:40], rec[19:8], rec[4], rec[0]);
                end
                default:
                begin
                    done = 1'b1;
                end
            endcase
            idx++;
        end

        if (check_count == 0)
        begin
            $display("No trace records were checked, the trace file may be missing");
            error_count++;
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/vtp_trace.txt ====
// Columns: kind _ APB address or VA _ write data, read data or PA _ not-present _ TLB hit
// Kind 1 is an APB write, 2 an APB read with expected data, 3 a lookup
// Line 1, hash head with tags 001 to 005 and a pointer to line 16
1_0010_02001A01_0_0
1_0014_3A03002A_0_0
1_0018_004A0400_0_0
1_001C_10005A05_0_0
// Line 16, full overflow line pointing on to line 17
1_0100_07006B06_0_0
1_0104_8B08007B_0_0
1_0108_009B0900_0_0
1_010C_1100AB0A_0_0
// Line 17, one PTE then a null tag
1_0110_0000BC0B_0_0
1_0114_00000000_0_0
1_0118_00000000_0_0
1_011C_00000000_0_0
// Line 2, full hash head with a null next pointer
1_0020_02001D01_0_0
1_0024_3D03002D_0_0
1_0028_004D0400_0_0
1_002C_00005D05_0_0
// Read back
2_0014_3A03002A_0_0
2_010C_1100AB0A_0_0
2_0020_02001D01_0_0
// Faults, null tag in line 17 and null pointer after line 2
3_00C1_00000000_1_0
3_00C1_00000000_1_0
3_0062_00000000_1_0
3_0062_00000000_1_0
// Head line PTEs in all five slots
3_0011_00000A01_0_0
3_0051_00000A05_0_0
3_0031_00000A03_0_0
3_0022_00000D02_0_0
3_0042_00000D04_0_0
// Overflow through one and two pointers
3_0071_00000B07_0_0
3_00A1_00000B0A_0_0
3_00B1_00000C0B_0_0
// Repeats that hit in the TLB
3_00B1_00000C0B_0_1
3_0042_00000D04_0_1
// Same TLB index, different tags
3_0011_00000A01_0_0
3_0021_00000A02_0_0
3_0011_00000A01_0_0
3_0021_00000A02_0_0
3_0021_00000A02_0_1

// ==== vlog.f ====
rtl/vtp_pkg.sv
rtl/vtp_fill_if.sv
rtl/vtp_pt_walk.sv
rtl/vtp_tlb.sv
rtl/vtp_pt_mem.sv
rtl/vtp_top.sv
tb/tb_vtp_top.sv
